/* source/match_pkg.sv */
// sizes are fixed at a 16x16 frame and a 6x6 kernel; the score widths hold only for 8-bit pixels and weights
package match_pkg;

	// frame and kernel geometry
	localparam int IMAGE_SIZE = 16;
	localparam int KERNEL_SIZE = 6;
	localparam int SCORES_PER_SIDE = IMAGE_SIZE - KERNEL_SIZE + 1;
	localparam int SCORES_PER_FRAME = SCORES_PER_SIDE * SCORES_PER_SIDE;

	// advances from a window row to its row sum: one for the products, one for the sum
	localparam int LANE_LATENCY = 2;

	// signed score at or above which a window counts as a hit
	localparam int MATCH_THRESHOLD = 2630;

	// flow control on both ends
	localparam int PIXEL_CREDITS = 4;
	localparam int RESULT_CREDITS = 4;
	localparam int RESULT_FIFO_DEPTH = 2;

	typedef logic [7:0] pixel_t;
	typedef logic signed [7:0] weight_t;

	// row times six plus column
	typedef logic [5:0] kernel_index_t;

	// six 8x8 products need 19 bits, six row sums need 22
	typedef logic signed [18:0] row_sum_t;
	typedef logic signed [21:0] score_t;

	typedef logic [6:0] hit_count_t;

	// px[0] is the leftmost column of the window
	typedef struct packed {
		pixel_t [0:KERNEL_SIZE-1] px;
	} window_row_t;

	typedef struct packed {
		logic valid;
		pixel_t pixel;
	} pixel_beat_t;

	typedef struct packed {
		logic valid;
		kernel_index_t index;
		weight_t weight;
	} kernel_write_t;

	typedef struct packed {
		logic valid;
		score_t score;
		logic hit;
	} match_result_t;

endpackage

/* source/window_feeder.sv */
// pixels must arrive only against pixel_credit; advance keeps running without a pixel until the last window of a frame has left the lanes
`timescale 1ns/1ns

module window_feeder (
	input  logic clk,
	input  logic rst,
	input  match_pkg::pixel_beat_t pixel_in,
	input  logic drain_ready,
	output logic pixel_credit,
	output logic advance,
	output logic window_valid,
	output match_pkg::window_row_t window_rows [match_pkg::KERNEL_SIZE]
);

	// input FIFO, sized to the credits the source holds
	match_pkg::pixel_t fifo_mem [match_pkg::PIXEL_CREDITS];
	logic [$clog2(match_pkg::PIXEL_CREDITS)-1:0] wr_ptr;
	logic [$clog2(match_pkg::PIXEL_CREDITS)-1:0] rd_ptr;
	logic [$clog2(match_pkg::PIXEL_CREDITS):0] fifo_count;
	logic fifo_has_pixel;
	logic pop;

	// raster position of the pixel at the FIFO head
	logic [$clog2(match_pkg::IMAGE_SIZE)-1:0] row_cnt;
	logic [$clog2(match_pkg::IMAGE_SIZE)-1:0] col_cnt;
	logic completes;

	// steps left before the newest valid window has reached the drain FIFO
	logic [$clog2(match_pkg::LANE_LATENCY + 2)-1:0] flush_cnt;

	// line_buf[0] holds the oldest image row
	match_pkg::pixel_t line_buf [match_pkg::KERNEL_SIZE-1][match_pkg::IMAGE_SIZE];
	match_pkg::pixel_t new_col [match_pkg::KERNEL_SIZE];

	assign fifo_has_pixel = (fifo_count != '0);
	assign advance = drain_ready && (fifo_has_pixel || (flush_cnt != '0));
	assign pop = advance && fifo_has_pixel;

	// the head pixel closes a window once five rows and five columns lie behind it
	assign completes = (int'(row_cnt) >= match_pkg::KERNEL_SIZE - 1) &&
		(int'(col_cnt) >= match_pkg::KERNEL_SIZE - 1);

	always_ff @(posedge clk) begin
		if (pixel_in.valid) begin
			fifo_mem[wr_ptr] <= pixel_in.pixel;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_count <= '0;
			pixel_credit <= 1'b0;
		end else begin
			if (pixel_in.valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({pixel_in.valid, pop})
				2'b10: fifo_count <= fifo_count + 1'b1;
				2'b01: fifo_count <= fifo_count - 1'b1;
				default: fifo_count <= fifo_count;
			endcase
			// every popped pixel frees one slot at the source
			pixel_credit <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			row_cnt <= '0;
			col_cnt <= '0;
			window_valid <= 1'b0;
			flush_cnt <= '0;
		end else if (advance) begin
			window_valid <= pop && completes;
			if (pop && completes) begin
				flush_cnt <= ($bits(flush_cnt))'(match_pkg::LANE_LATENCY + 1);
			end else if (flush_cnt != '0) begin
				flush_cnt <= flush_cnt - 1'b1;
			end
			if (pop) begin
				if (int'(col_cnt) == match_pkg::IMAGE_SIZE - 1) begin
					col_cnt <= '0;
					if (int'(row_cnt) == match_pkg::IMAGE_SIZE - 1) begin
						row_cnt <= '0;
					end else begin
						row_cnt <= row_cnt + 1'b1;
					end
				end else begin
					col_cnt <= col_cnt + 1'b1;
				end
			end
		end
	end

	// column entering the window, top row first
	always_comb begin
		for (int r = 0; r < match_pkg::KERNEL_SIZE - 1; r++) begin
			new_col[r] = line_buf[r][col_cnt];
		end
		new_col[match_pkg::KERNEL_SIZE-1] = fifo_mem[rd_ptr];
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			// each line moves up by one row at this column
			for (int r = 0; r < match_pkg::KERNEL_SIZE - 1; r++) begin
				line_buf[r][col_cnt] <= new_col[r+1];
			end
			for (int r = 0; r < match_pkg::KERNEL_SIZE; r++) begin
				for (int c = 0; c < match_pkg::KERNEL_SIZE - 1; c++) begin
					window_rows[r].px[c] <= window_rows[r].px[c+1];
				end
				window_rows[r].px[match_pkg::KERNEL_SIZE-1] <= new_col[r];
			end
		end
	end

endmodule

/* source/row_correlator.sv */
// kernel_wr must already be limited to this lane's row; rewriting weights while a frame still produces scores is unsupported
`timescale 1ns/1ns

module row_correlator (
	input  logic clk,
	input  logic rst,
	input  match_pkg::kernel_write_t kernel_wr,
	input  logic advance,
	input  match_pkg::window_row_t window_row,
	output match_pkg::row_sum_t row_sum
);

	match_pkg::weight_t weights [match_pkg::KERNEL_SIZE];

	// an unsigned pixel times a signed weight fits in 16 signed bits
	logic signed [15:0] products [match_pkg::KERNEL_SIZE];
	match_pkg::row_sum_t sum_next;

	// the column is what remains of the index once the row is known
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < match_pkg::KERNEL_SIZE; c++) begin
				weights[c] <= '0;
			end
		end else if (kernel_wr.valid) begin
			weights[int'(kernel_wr.index) % match_pkg::KERNEL_SIZE] <= kernel_wr.weight;
		end
	end

	// first step of the lane
	always_ff @(posedge clk) begin
		if (advance) begin
			for (int c = 0; c < match_pkg::KERNEL_SIZE; c++) begin
				products[c] <= $signed({1'b0, window_row.px[c]}) * weights[c];
			end
		end
	end

	always_comb begin
		sum_next = '0;
		for (int c = 0; c < match_pkg::KERNEL_SIZE; c++) begin
			sum_next += match_pkg::row_sum_t'(products[c]);
		end
	end

	// second step, the products of the previous advance are summed
	always_ff @(posedge clk) begin
		if (advance) begin
			row_sum <= sum_next;
		end
	end

endmodule

/* source/score_drain.sv */
// a result leaves only while a credit is held, and the consumer returns one result_credit per result it frees
`timescale 1ns/1ns

module score_drain (
	input  logic clk,
	input  logic rst,
	input  logic advance,
	input  logic window_valid,
	input  match_pkg::row_sum_t row_sums [match_pkg::KERNEL_SIZE],
	input  logic result_credit,
	output logic drain_ready,
	output match_pkg::match_result_t result,
	output logic frame_done,
	output match_pkg::hit_count_t hit_count
);

	// a queued score with its hit flag
	typedef struct packed {
		match_pkg::score_t score;
		logic hit;
	} fifo_entry_t;

	// window_valid travels alongside the lanes so it lines up with the row sums
	logic [match_pkg::LANE_LATENCY-1:0] valid_dly;
	match_pkg::score_t score;
	logic hit;
	logic push;

	fifo_entry_t fifo_mem [match_pkg::RESULT_FIFO_DEPTH];
	logic [$clog2(match_pkg::RESULT_FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(match_pkg::RESULT_FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(match_pkg::RESULT_FIFO_DEPTH):0] fifo_count;

	logic [$clog2(match_pkg::RESULT_CREDITS):0] credits;
	logic send;

	logic res_valid;
	match_pkg::score_t res_score;
	logic res_hit;

	logic [$clog2(match_pkg::SCORES_PER_FRAME)-1:0] score_cnt;
	logic last_score;
	// set until the first hit of a frame, so the previous total stays visible until then
	logic count_fresh;

	always_comb begin
		score = '0;
		for (int r = 0; r < match_pkg::KERNEL_SIZE; r++) begin
			score += match_pkg::score_t'(row_sums[r]);
		end
	end

	assign hit = (score >= match_pkg::MATCH_THRESHOLD);
	assign push = advance && valid_dly[match_pkg::LANE_LATENCY-1];
	assign send = (fifo_count != '0) && (credits != '0);

	// a send in this cycle frees the slot the next push may need
	assign drain_ready = (int'(fifo_count) < match_pkg::RESULT_FIFO_DEPTH) || send;
	assign last_score = (int'(score_cnt) == match_pkg::SCORES_PER_FRAME - 1);

	assign result = {res_valid, res_score, res_hit};

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_dly <= '0;
		end else if (advance) begin
			valid_dly <= {valid_dly[match_pkg::LANE_LATENCY-2:0], window_valid};
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= {score, hit};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_count <= '0;
			credits <= ($bits(credits))'(match_pkg::RESULT_CREDITS);
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (send) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, send})
				2'b10: fifo_count <= fifo_count + 1'b1;
				2'b01: fifo_count <= fifo_count - 1'b1;
				default: fifo_count <= fifo_count;
			endcase
			// a returned credit and a send in the same cycle cancel out
			case ({send, result_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= send;
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			res_score <= fifo_mem[rd_ptr].score;
			res_hit <= fifo_mem[rd_ptr].hit;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			score_cnt <= '0;
			frame_done <= 1'b0;
			hit_count <= '0;
			count_fresh <= 1'b1;
		end else begin
			frame_done <= send && last_score;
			if (send) begin
				score_cnt <= last_score ? '0 : score_cnt + 1'b1;
				if (fifo_mem[rd_ptr].hit) begin
					hit_count <= count_fresh ? match_pkg::hit_count_t'(1) : hit_count + 1'b1;
					count_fresh <= 1'b0;
				end else if (last_score && count_fresh) begin
					// a frame without any hit still has to report zero
					hit_count <= '0;
				end
				if (last_score) begin
					count_fresh <= 1'b1;
				end
			end
		end
	end

endmodule

/* source/pattern_matcher.sv */
// load all 36 weights before a frame starts; pixels and results both move only against credits
`timescale 1ns/1ns

module pattern_matcher (
	input  logic clk,
	input  logic rst,
	input  match_pkg::pixel_beat_t pixel_in,
	input  match_pkg::kernel_write_t kernel_wr,
	input  logic result_credit,
	output logic pixel_credit,
	output match_pkg::match_result_t result,
	output logic frame_done,
	output match_pkg::hit_count_t hit_count
);

	logic advance;
	logic window_valid;
	logic drain_ready;
	match_pkg::window_row_t window_rows [match_pkg::KERNEL_SIZE];
	match_pkg::row_sum_t row_sums [match_pkg::KERNEL_SIZE];
	match_pkg::kernel_write_t lane_wr [match_pkg::KERNEL_SIZE];

	window_feeder u_feeder (
		.clk(clk),
		.rst(rst),
		.pixel_in(pixel_in),
		.drain_ready(drain_ready),
		.pixel_credit(pixel_credit),
		.advance(advance),
		.window_valid(window_valid),
		.window_rows(window_rows)
	);

	// one lane per kernel row, each sees only the writes for its own row
	for (genvar lane = 0; lane < match_pkg::KERNEL_SIZE; lane++) begin : g_lane
		assign lane_wr[lane] = {
			kernel_wr.valid && (int'(kernel_wr.index) / match_pkg::KERNEL_SIZE == lane),
			kernel_wr.index,
			kernel_wr.weight
		};

		row_correlator u_corr (
			.clk(clk),
			.rst(rst),
			.kernel_wr(lane_wr[lane]),
			.advance(advance),
			.window_row(window_rows[lane]),
			.row_sum(row_sums[lane])
		);
	end

	score_drain u_drain (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.window_valid(window_valid),
		.row_sums(row_sums),
		.result_credit(result_credit),
		.drain_ready(drain_ready),
		.result(result),
		.frame_done(frame_done),
		.hit_count(hit_count)
	);

endmodule

/* testbench/match_checker.sv */
// reference model of the matcher; it assumes the kernel is not rewritten while a frame is scored
`timescale 1ns/1ns

module match_checker (
	input  logic clk,
	input  logic rst,
	input  match_pkg::pixel_beat_t pixel_in,
	input  match_pkg::kernel_write_t kernel_wr,
	input  logic result_credit,
	input  logic pixel_credit,
	input  match_pkg::match_result_t result,
	input  logic frame_done,
	input  match_pkg::hit_count_t hit_count,
	input  logic run_done,
	output int error_count
);

	localparam int TAPS = match_pkg::KERNEL_SIZE * match_pkg::KERNEL_SIZE;
	localparam int FRAME_PIXELS = match_pkg::IMAGE_SIZE * match_pkg::IMAGE_SIZE;

	int weights_now [TAPS];
	// pixels by arrival number, kernels by frame number times the tap count
	int pixel_mem [int];
	int kernel_mem [int];
	int pixels_seen;
	int pixel_credits_seen;
	int results_seen;
	int result_credits_seen;
	int frame_hits;
	bit end_checked;

	// plain correlation of one window with the kernel of its frame
	function automatic int expected_score(input int k);
		int frame;
		int pos;
		int row0;
		int col0;
		int sum;
		frame = k / match_pkg::SCORES_PER_FRAME;
		pos = k % match_pkg::SCORES_PER_FRAME;
		row0 = pos / match_pkg::SCORES_PER_SIDE;
		col0 = pos % match_pkg::SCORES_PER_SIDE;
		sum = 0;
		for (int r = 0; r < match_pkg::KERNEL_SIZE; r++) begin
			for (int c = 0; c < match_pkg::KERNEL_SIZE; c++) begin
				sum += pixel_mem[frame * FRAME_PIXELS + (row0 + r) * match_pkg::IMAGE_SIZE + col0 + c] *
					kernel_mem[frame * TAPS + r * match_pkg::KERNEL_SIZE + c];
			end
		end
		return sum;
	endfunction

	always @(posedge clk) begin
		int expected;
		bit expected_hit;
		bit last_of_frame;
		if (!rst) begin
			if (pixels_seen == 0 && (pixel_credit !== 1'b0 || result.valid !== 1'b0 ||
				frame_done !== 1'b0 || hit_count !== '0)) begin
				$display("outputs left their idle values before the first pixel was sent");
				error_count++;
			end
			if (kernel_wr.valid) begin
				weights_now[int'(kernel_wr.index)] = int'($signed(kernel_wr.weight));
			end
			if (pixel_in.valid) begin
				// the kernel in place at a frame's first pixel belongs to that frame
				if (pixels_seen % FRAME_PIXELS == 0) begin
					for (int i = 0; i < TAPS; i++) begin
						kernel_mem[(pixels_seen / FRAME_PIXELS) * TAPS + i] = weights_now[i];
					end
				end
				pixel_mem[pixels_seen] = int'(pixel_in.pixel);
				pixels_seen++;
			end
			if (pixel_credit) begin
				pixel_credits_seen++;
				if (pixel_credits_seen > pixels_seen) begin
					$display("pixel_credit returned more credits than pixels were sent");
					error_count++;
				end
			end
			if (result_credit) begin
				result_credits_seen++;
			end
			if (result.valid) begin
				expected = expected_score(results_seen);
				expected_hit = (expected >= match_pkg::MATCH_THRESHOLD);
				last_of_frame = (results_seen % match_pkg::SCORES_PER_FRAME ==
					match_pkg::SCORES_PER_FRAME - 1);
				if (int'($signed(result.score)) != expected) begin
					$display("FAILED result.score at result %0d: expected 0x%h got 0x%h",
						results_seen, match_pkg::score_t'(expected), result.score);
					error_count++;
				end
				if (result.hit !== expected_hit) begin
					$display("FAILED result.hit at result %0d: expected 0x%h got 0x%h",
						results_seen, expected_hit, result.hit);
					error_count++;
				end
				if (frame_done !== last_of_frame) begin
					$display("FAILED frame_done at result %0d: expected 0x%h got 0x%h",
						results_seen, last_of_frame, frame_done);
					error_count++;
				end
				frame_hits += int'(expected_hit);
				if (last_of_frame) begin
					if (hit_count !== match_pkg::hit_count_t'(frame_hits)) begin
						$display("FAILED hit_count at result %0d: expected 0x%h got 0x%h",
							results_seen, match_pkg::hit_count_t'(frame_hits), hit_count);
						error_count++;
					end
					frame_hits = 0;
				end
				results_seen++;
				if (results_seen - result_credits_seen > match_pkg::RESULT_CREDITS) begin
					$display("more results are outstanding than the consumer has credits for");
					error_count++;
				end
			end else if (frame_done) begin
				$display("frame_done pulsed in a cycle without a result");
				error_count++;
			end
			if (run_done && !end_checked) begin
				end_checked = 1'b1;
				if (pixel_credits_seen != pixels_seen) begin
					$display("FAILED pixel_credit count: expected 0x%h got 0x%h",
						pixels_seen, pixel_credits_seen);
					error_count++;
				end
				if (results_seen != pixels_seen / FRAME_PIXELS * match_pkg::SCORES_PER_FRAME) begin
					$display("FAILED result count: expected 0x%h got 0x%h",
						pixels_seen / FRAME_PIXELS * match_pkg::SCORES_PER_FRAME, results_seen);
					error_count++;
				end
			end
		end
	end

endmodule

/* testbench/tb_pattern_matcher.sv */
// runs three random frames with random pixel gaps and slow result credits; the random sequence is fixed by its seed
`timescale 1ns/1ns

module tb_pattern_matcher;

	localparam int FRAMES = 3;
	localparam int TAPS = match_pkg::KERNEL_SIZE * match_pkg::KERNEL_SIZE;
	localparam int FRAME_PIXELS = match_pkg::IMAGE_SIZE * match_pkg::IMAGE_SIZE;
	// about twenty cycles per pixel leaves room for the slowest credit return
	localparam int TIMEOUT_CYCLES = FRAMES * (TAPS + FRAME_PIXELS * 20);

	logic clk = 1'b0;
	logic rst;
	match_pkg::pixel_beat_t pixel_in;
	match_pkg::kernel_write_t kernel_wr;
	logic result_credit = 1'b0;
	logic pixel_credit;
	match_pkg::match_result_t result;
	logic frame_done;
	match_pkg::hit_count_t hit_count;
	logic run_done;
	int checker_errors;

	int cycle_count;
	int pixels_sent;
	int pixel_credits_back;
	int frames_done;
	int results_seen;
	int credits_returned;
	// cycle at which each result's credit goes back to the DUT
	int credit_due [$];

	pattern_matcher uut (
		.clk(clk),
		.rst(rst),
		.pixel_in(pixel_in),
		.kernel_wr(kernel_wr),
		.result_credit(result_credit),
		.pixel_credit(pixel_credit),
		.result(result),
		.frame_done(frame_done),
		.hit_count(hit_count)
	);

	match_checker u_checker (
		.clk(clk),
		.rst(rst),
		.pixel_in(pixel_in),
		.kernel_wr(kernel_wr),
		.result_credit(result_credit),
		.pixel_credit(pixel_credit),
		.result(result),
		.frame_done(frame_done),
		.hit_count(hit_count),
		.run_done(run_done),
		.error_count(checker_errors)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (pixel_credit) begin
			pixel_credits_back++;
		end
		if (frame_done) begin
			frames_done++;
		end
		if (result.valid) begin
			credit_due.push_back(cycle_count + int'($urandom % 7));
			results_seen++;
		end
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles with %0d of %0d frames done",
				cycle_count, frames_done, FRAMES);
			$display("errors: %0d", checker_errors + 1);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// at most one credit per cycle, in the order the results came
	always @(negedge clk) begin
		if (credits_returned < results_seen && credit_due[credits_returned] <= cycle_count) begin
			result_credit = 1'b1;
			credits_returned++;
		end else begin
			result_credit = 1'b0;
		end
	end

	task automatic load_kernel();
		for (int i = 0; i < TAPS; i++) begin
			kernel_wr.valid = 1'b1;
			kernel_wr.index = match_pkg::kernel_index_t'(i);
			kernel_wr.weight = match_pkg::weight_t'($urandom);
			@(negedge clk);
		end
		kernel_wr.valid = 1'b0;
	endtask

	task automatic send_pixel();
		int gap;
		gap = $urandom % 3;
		repeat (gap) @(negedge clk);
		while (pixels_sent - pixel_credits_back >= match_pkg::PIXEL_CREDITS) begin
			@(negedge clk);
		end
		pixel_in.valid = 1'b1;
		pixel_in.pixel = match_pkg::pixel_t'($urandom);
		pixels_sent++;
		@(negedge clk);
		pixel_in.valid = 1'b0;
	endtask

	initial begin
		void'($urandom(27));
		rst = 1'b1;
		pixel_in = '0;
		kernel_wr = '0;
		run_done = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int f = 0; f < FRAMES; f++) begin
			load_kernel();
			for (int p = 0; p < FRAME_PIXELS; p++) begin
				send_pixel();
			end
			while (frames_done <= f) begin
				@(negedge clk);
			end
		end
		run_done = 1'b1;
		repeat (2) @(negedge clk);
		$display("errors: %0d", checker_errors);
		if (checker_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* project.f */
source/match_pkg.sv
source/window_feeder.sv
source/row_correlator.sv
source/score_drain.sv
source/pattern_matcher.sv
testbench/match_checker.sv
testbench/tb_pattern_matcher.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_pattern_matcher -f project.f -o sim_pattern_matcher
	./obj_dir/sim_pattern_matcher | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
